// ==== filelist.f ====
src/nes_input_pkg.sv
src/host_reg_decoder.sv
src/autofire.sv
src/player_port.sv
src/joypad_bus.sv
src/nes_input_top.sv
sim/nes_input_checker.sv
sim/tb_nes_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_nes_input -f filelist.f -o sim_nes_input > sim.log 2>&1 \
  && ./obj_dir/sim_nes_input >> sim.log 2>&1
grep -q "^All checks passed$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim/nes_input_checker.sv ====
// --------------------
// assertions bound into nes_input_top
// serial data after reset, shift pulses and the menu OR
// --------------------
module nes_input_checker #(
  parameter int NUM_PLAYERS = 2
) (
  input logic                        clk,
  input logic                        sys_resetn,
  input logic                        joypad_clock [NUM_PLAYERS],
  input logic                        shift        [NUM_PLAYERS],
  input logic                        joypad_data  [NUM_PLAYERS],
  input nes_input_pkg::nes_buttons_t port_buttons [NUM_PLAYERS],
  input nes_input_pkg::nes_buttons_t menu_buttons
);
  timeunit 1ns;
  timeprecision 100ps;
  import nes_input_pkg::*;

  nes_buttons_t any_buttons;

  always_comb begin
    any_buttons = '0;
    for (int p = 0; p < NUM_PLAYERS; p++) begin
      any_buttons = any_buttons | port_buttons[p];
    end
  end

  for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
    a_data_low_after_reset : assert property (
      @(posedge clk) !sys_resetn |=> !joypad_data[p]
    ) else $error("joypad_data of player %0d high after reset", p);

    // a fall needs the clock high one edge earlier
    a_shift_needs_high_clock : assert property (
      @(posedge clk) disable iff (!sys_resetn) shift[p] |-> $past(joypad_clock[p])
    ) else $error("shift pulse of player %0d without a high joypad clock", p);
  end

  a_menu_is_or : assert property (
    @(posedge clk) disable iff (!sys_resetn) menu_buttons == any_buttons
  ) else $error("menu_buttons is not the OR of the port buttons");

endmodule

bind nes_input_top nes_input_checker #(.NUM_PLAYERS(NUM_PLAYERS)) u_checker (
  .clk         (clk),
  .sys_resetn  (sys_resetn),
  .joypad_clock(joypad_clock),
  .shift       (shift),
  .joypad_data (joypad_data),
  .port_buttons(port_buttons),
  .menu_buttons(menu_buttons)
);

// ==== sim/tb_nes_input.sv ====
// --------------------
// testbench for the controller input path
// random pad, usb, host and joypad stimulus from an LCG
// every cycle is compared with a cycle model of overlays, autofire and shift registers
// --------------------
module tb_nes_input;
  timeunit 1ns;
  timeprecision 100ps;
  import nes_input_pkg::*;

  localparam int NP     = 2;
  localparam int PERIOD = 8;

  logic         clk;
  logic         sys_resetn;
  host_wr_t     host_wr;
  pad_bytes_t   pads [NP];
  usb_buttons_t usb [NP];
  logic         joypad_strobe;
  logic         joypad_clock [NP];
  logic         joypad_data [NP];
  nes_buttons_t menu_buttons;

  nes_buttons_t m_ov [NP];
  nes_buttons_t m_sh [NP];
  logic         m_clk_q [NP];
  logic         m_held [NP][2];  // index 0 is square and 1 is triangle
  int           m_cnt [NP][2];
  logic [31:0]  seed = 32'hdce7b46e;

  nes_input_top #(.NUM_PLAYERS(NP), .AUTOFIRE_PERIOD(PERIOD)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // autofire inputs with square or usb y in bit 0 and triangle or usb x in bit 1
  function automatic logic [1:0] af_inputs(int p);
    return {~pads[p].face[4] | usb[p].x, ~pads[p].face[7] | usb[p].y};
  endfunction

  function automatic nes_buttons_t model_buttons(int p);
    pad_byte_t    d;
    pad_byte_t    f;
    nes_buttons_t b;
    d = ~pads[p].dirs;
    f = ~pads[p].face;
    b = {d[5], d[7], d[6], d[4], d[3], d[0], f[6], f[5]};  // cross is B and circle is A
    b[1] = b[1] | (m_held[p][0] && m_cnt[p][0] < PERIOD / 2);
    b[0] = b[0] | (m_held[p][1] && m_cnt[p][1] < PERIOD / 2);
    return b | usb[p].btn | m_ov[p];
  endfunction

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      $display("Checks failed");
      $fatal(1, "serial bit mismatch");
    end
  endtask

  task automatic check_buttons(string name, nes_buttons_t exp, nes_buttons_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "button mismatch");
    end
  endtask

  // state update as seen at a rising clock edge
  task automatic model_step();
    logic [1:0] hold;
    for (int p = 0; p < NP; p++) begin
      hold = af_inputs(p);
      if (!sys_resetn) begin
        m_ov[p]    = '0;
        m_sh[p]    = '0;
        m_clk_q[p] = 1'b0;
        m_held[p]  = '{1'b0, 1'b0};
        m_cnt[p]   = '{0, 0};
      end else begin
        if (m_clk_q[p] && !joypad_clock[p]) m_sh[p] = m_sh[p] >> 1;  // shift beats load
        else if (joypad_strobe) m_sh[p] = model_buttons(p);
        m_clk_q[p] = joypad_clock[p];
        if (host_wr.valid && host_wr.addr == reg_addr_t'(8'h40 + p)) m_ov[p] = host_wr.data;
        for (int a = 0; a < 2; a++) begin
          if (!hold[a] || !m_held[p][a]) m_cnt[p][a] = 0;
          else m_cnt[p][a] = (m_cnt[p][a] + 1) % PERIOD;
          m_held[p][a] = hold[a];
        end
      end
    end
  endtask

  // one clock and a compare at the falling edge before new inputs
  task automatic cycle(string name = "cycle");
    nes_buttons_t menu;
    @(posedge clk);
    model_step();
    @(negedge clk);
    menu = '0;
    for (int p = 0; p < NP; p++) begin
      menu = menu | model_buttons(p);
      check_bit(name, m_sh[p][0], joypad_data[p]);
    end
    check_buttons(name, menu, menu_buttons);
  endtask

  task automatic wait_menu_bit(int idx, logic value, int limit);
    int n;
    n = 0;
    while (menu_buttons[idx] !== value) begin
      if (n == limit) begin
        $display("timed out waiting for menu button bit %0d to become %b", idx, value);
        $display("Checks failed");
        $fatal(1, "wait timeout");
      end
      cycle("autofire");
      n++;
    end
  endtask

  task automatic host_write(reg_addr_t addr, reg_data_t data);
    host_wr = {1'b1, addr, data};
    cycle("host_write");
    host_wr.valid = 1'b0;
  endtask

  // strobe and ten falls that read eight buttons and two zero-fill bits
  task automatic read_player(int p, string name);
    nes_buttons_t exp;
    joypad_strobe = 1'b1;
    cycle(name);
    joypad_strobe = 1'b0;
    exp = m_sh[p];
    for (int i = 0; i < 10; i++) begin
      check_bit(name, (i < 8) ? exp[i] : 1'b0, joypad_data[p]);
      joypad_clock[p] = 1'b1;
      cycle(name);
      joypad_clock[p] = 1'b0;
      cycle(name);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    sys_resetn    = 1'b0;
    host_wr       = '0;
    joypad_strobe = 1'b0;
    for (int p = 0; p < NP; p++) begin
      pads[p]         = '1;  // all released
      usb[p]          = '0;
      joypad_clock[p] = 1'b0;
    end
    cycle("reset");
    cycle("reset");
    sys_resetn = 1'b1;

    for (int k = 0; k < 4; k++) begin
      for (int p = 0; p < NP; p++) begin
        r = lcg_next();
        pads[p] = {r[15:8], r[7:0] | 8'h90};  // square and triangle released
      end
      read_player(0, "pad_map");
      read_player(1, "pad_map");
      r  = lcg_next();
      r2 = lcg_next();
      host_write(8'h40, r[7:0]);
      host_write(8'h41, r[15:8]);
      host_write({1'b1, r[22:16]}, r2[7:0]);  // never 0x40 or 0x41
      read_player(0, "overlay");
      read_player(1, "overlay");
      usb[0] = {r2[15:8], 2'b00};
      usb[1] = {r2[23:16], 2'b00};
      read_player(0, "usb_merge");
      read_player(1, "usb_merge");
      usb[0] = '0;
      usb[1] = '0;
      host_write(8'h40, 8'h00);  // overlays back to zero for the next pad read
      host_write(8'h41, 8'h00);
    end

    // shift and strobe in the same cycle
    pads[0] = '1;
    pads[1] = '1;
    host_write(8'h40, 8'h02);
    joypad_strobe = 1'b1;
    cycle("shift_wins");
    joypad_strobe   = 1'b0;
    joypad_clock[0] = 1'b1;
    cycle("shift_wins");
    joypad_clock[0] = 1'b0;
    joypad_strobe   = 1'b1;
    cycle("shift_wins");
    check_bit("shift_wins", 1'b1, joypad_data[0]);
    joypad_strobe = 1'b0;
    cycle("shift_wins");

    host_write(8'h40, 8'h00);
    host_write(8'h41, 8'h00);
    joypad_strobe = 1'b1;
    pads[0].face[7] = 1'b0;  // square held on player 0
    usb[1].x = 1'b1;         // triangle autofire on player 1
    wait_menu_bit(1, 1'b1, 4);
    repeat (3 * PERIOD) cycle("autofire");
    pads[0].face[7] = 1'b1;
    usb[1].x = 1'b0;
    wait_menu_bit(1, 1'b0, 4);
    repeat (PERIOD) cycle("autofire");
    joypad_strobe = 1'b0;

    for (int i = 0; i < 300; i++) begin
      r  = lcg_next();
      r2 = lcg_next();
      pads[i % NP]         = r[15:0];
      usb[i % NP]          = r[25:16];
      joypad_strobe        = r[26];
      joypad_clock[i % NP] = r[27];
      host_wr = {r[28], r[30], 6'b100000, r[29], r2[7:0]};  // address 0x40, 0x41, 0xc0 or 0xc1
      cycle("random");
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== src/autofire.sv ====
// ------------------
// autofire for one button
// while btn is held, fire is a square wave with the given period
// ------------------
module autofire #(
  parameter int AUTOFIRE_PERIOD = 540000  // 50 Hz at 27 MHz
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic fire
);

  localparam int CNT_W       = (AUTOFIRE_PERIOD > 2) ? $clog2(AUTOFIRE_PERIOD) : 1;
  localparam int HALF_PERIOD = AUTOFIRE_PERIOD / 2;

  logic [CNT_W-1:0] count;
  logic             held;   // btn seen at the last edge

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      count <= '0;
      held  <= 1'b0;
    end else begin
      held <= btn;
      if (!btn || !held) begin
        count <= '0;                // restart on press, clear on release
      end else if (count == CNT_W'(AUTOFIRE_PERIOD - 1)) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign fire = held && (count < CNT_W'(HALF_PERIOD));  // first half of each period

endmodule

// ==== src/host_reg_decoder.sv ====
// ------------------
// host register decoder for the button overlay
// takes decoded UART writes and keeps one overlay byte per player
// ------------------
module host_reg_decoder #(
  parameter int NUM_PLAYERS = 2
) (
  input  logic                     clk,
  input  logic                     sys_resetn,
  input  nes_input_pkg::host_wr_t  host_wr,
  output nes_input_pkg::nes_buttons_t overlay [NUM_PLAYERS]
);
  import nes_input_pkg::*;

  // one register per player, each at its own address
  for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player

    localparam reg_addr_t REG_ADDR = PLAYER_BTN_BASE + reg_addr_t'(p);

    logic hit;

    assign hit = host_wr.valid && (host_wr.addr == REG_ADDR);

    always_ff @(posedge clk) begin
      if (!sys_resetn) begin
        overlay[p] <= '0;
      end else if (hit) begin
        overlay[p] <= nes_buttons_t'(host_wr.data);  // host writes in console order
      end
    end

  end

endmodule

// ==== src/joypad_bus.sv ====
// ------------------
// joypad bus between the console and the player ports
// turns falling joypad clocks into shift pulses, forwards the strobe
// and gathers the serial bits and the menu buttons
// ------------------
module joypad_bus #(
  parameter int NUM_PLAYERS = 2
) (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  logic                        joypad_strobe,
  input  logic                        joypad_clock [NUM_PLAYERS],
  input  logic                        serial       [NUM_PLAYERS],
  input  nes_input_pkg::nes_buttons_t buttons      [NUM_PLAYERS],
  output logic                        strobe,
  output logic                        shift        [NUM_PLAYERS],
  output logic                        joypad_data  [NUM_PLAYERS],
  output nes_input_pkg::nes_buttons_t menu_buttons
);

  assign strobe = joypad_strobe;  // same strobe for all ports

  for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player

    logic clock_q;  // joypad clock at the last edge

    always_ff @(posedge clk) begin
      if (!sys_resetn) begin
        clock_q <= 1'b0;
      end else begin
        clock_q <= joypad_clock[p];
      end
    end

    // high for one cycle after the clock drops
    assign shift[p] = clock_q & ~joypad_clock[p];

    assign joypad_data[p] = serial[p];

  end

  // any player's buttons drive the menu
  always_comb begin
    menu_buttons = '0;
    for (int p = 0; p < NUM_PLAYERS; p++) begin
      menu_buttons = menu_buttons | buttons[p];
    end
  end

endmodule

// ==== src/nes_input_pkg.sv ====
// ------------------
// shared types and constants for the controller input path
// button order, Dualshock bit positions and host register map
// imported by every RTL module that needs them
// ------------------
package nes_input_pkg;

  // console buttons, bit 7 down to 0: right left down up start select B A
  typedef logic [7:0] nes_buttons_t;

  typedef logic [7:0] pad_byte_t;  // Dualshock rx byte, active low
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  typedef struct packed {
    pad_byte_t dirs;  // select, start, d-pad
    pad_byte_t face;  // triangle, circle, cross, square
  } pad_bytes_t;

  typedef struct packed {
    nes_buttons_t btn;  // already in console order
    logic         x;    // drives A autofire
    logic         y;    // drives B autofire
  } usb_buttons_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    reg_data_t data;
  } host_wr_t;

  // bit positions in nes_buttons_t
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // bit positions in the pad dirs byte
  localparam int PAD_SELECT = 0;
  localparam int PAD_START  = 3;
  localparam int PAD_UP     = 4;
  localparam int PAD_RIGHT  = 5;
  localparam int PAD_DOWN   = 6;
  localparam int PAD_LEFT   = 7;

  // bit positions in the pad face byte
  localparam int PAD_TRIANGLE = 4;
  localparam int PAD_CIRCLE   = 5;
  localparam int PAD_CROSS    = 6;
  localparam int PAD_SQUARE   = 7;

  localparam reg_addr_t PLAYER_BTN_BASE = 8'h40;  // player n at base + n
  localparam int        MAX_PLAYERS     = 4;      // keeps clear of other registers

endpackage

// ==== src/nes_input_top.sv ====
// ------------------
// top level of the controller input path
// host overlay decoder, one port per player and the joypad bus
// NUM_PLAYERS and AUTOFIRE_PERIOD are set here and passed down
// ------------------
module nes_input_top #(
  parameter int NUM_PLAYERS     = 2,
  parameter int AUTOFIRE_PERIOD = 540000
) (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_input_pkg::host_wr_t     host_wr,
  input  nes_input_pkg::pad_bytes_t   pads         [NUM_PLAYERS],
  input  nes_input_pkg::usb_buttons_t usb          [NUM_PLAYERS],
  input  logic                        joypad_strobe,
  input  logic                        joypad_clock [NUM_PLAYERS],
  output logic                        joypad_data  [NUM_PLAYERS],
  output nes_input_pkg::nes_buttons_t menu_buttons
);
  import nes_input_pkg::*;

  // more players would run into the next register block
  if (NUM_PLAYERS > MAX_PLAYERS) begin : g_too_many_players
    $fatal(1, "NUM_PLAYERS above MAX_PLAYERS");
  end

  nes_buttons_t overlay      [NUM_PLAYERS];
  nes_buttons_t port_buttons [NUM_PLAYERS];
  logic         serial       [NUM_PLAYERS];
  logic         shift        [NUM_PLAYERS];
  logic         strobe;

  host_reg_decoder #(
    .NUM_PLAYERS(NUM_PLAYERS)
  ) u_host_reg_decoder (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .host_wr   (host_wr),
    .overlay   (overlay)
  );

  for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_port
    player_port #(
      .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
    ) u_player_port (
      .clk       (clk),
      .sys_resetn(sys_resetn),
      .pad       (pads[p]),
      .usb       (usb[p]),
      .overlay   (overlay[p]),
      .strobe    (strobe),
      .shift     (shift[p]),
      .buttons   (port_buttons[p]),
      .serial    (serial[p])
    );
  end

  joypad_bus #(
    .NUM_PLAYERS(NUM_PLAYERS)
  ) u_joypad_bus (
    .clk          (clk),
    .sys_resetn   (sys_resetn),
    .joypad_strobe(joypad_strobe),
    .joypad_clock (joypad_clock),
    .serial       (serial),
    .buttons      (port_buttons),
    .strobe       (strobe),
    .shift        (shift),
    .joypad_data  (joypad_data),
    .menu_buttons (menu_buttons)
  );

endmodule

// ==== src/player_port.sv ====
// ------------------
// one player's controller port
// maps the Dualshock bytes to console order, adds autofire, usb and
// overlay buttons, then latches on strobe and shifts out bit 0 first
// ------------------
module player_port #(
  parameter int AUTOFIRE_PERIOD = 540000
) (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_input_pkg::pad_bytes_t   pad,
  input  nes_input_pkg::usb_buttons_t usb,
  input  nes_input_pkg::nes_buttons_t overlay,
  input  logic                        strobe,
  input  logic                        shift,
  output nes_input_pkg::nes_buttons_t buttons,
  output logic                        serial
);
  import nes_input_pkg::*;

  nes_buttons_t mapped;
  nes_buttons_t shreg;
  logic         square_held;
  logic         triangle_held;
  logic         fire_square;
  logic         fire_triangle;

  // pad bits are active low
  assign square_held   = ~pad.face[PAD_SQUARE] | usb.y;
  assign triangle_held = ~pad.face[PAD_TRIANGLE] | usb.x;

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) u_af_square (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .btn       (square_held),
    .fire      (fire_square)
  );

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) u_af_triangle (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .btn       (triangle_held),
    .fire      (fire_triangle)
  );

  always_comb begin
    mapped             = '0;
    mapped[BTN_RIGHT]  = ~pad.dirs[PAD_RIGHT];
    mapped[BTN_LEFT]   = ~pad.dirs[PAD_LEFT];
    mapped[BTN_DOWN]   = ~pad.dirs[PAD_DOWN];
    mapped[BTN_UP]     = ~pad.dirs[PAD_UP];
    mapped[BTN_START]  = ~pad.dirs[PAD_START];
    mapped[BTN_SELECT] = ~pad.dirs[PAD_SELECT];
    mapped[BTN_B]      = ~pad.face[PAD_CROSS] | fire_square;    // cross is B
    mapped[BTN_A]      = ~pad.face[PAD_CIRCLE] | fire_triangle; // circle is A
  end

  assign buttons = mapped | usb.btn | overlay;

  // console reads A first, then B, select, start, up, down, left, right
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shreg <= '0;
    end else if (shift) begin
      shreg <= {1'b0, shreg[7:1]};  // shift wins over a load in the same cycle
    end else if (strobe) begin
      shreg <= buttons;
    end
  end

  assign serial = shreg[0];

endmodule
